// File: verilog/rob_cfg_pkg.sv
`default_nettype none

package rob_cfg_pkg;

  // instructions per dispatch, also max retires per cycle
  localparam int num_super = 2;

  // reorder buffer depth, power of two so pointers wrap
  localparam int num_rob = 16;

  localparam int num_areg = 32;

  // physical register file, num_areg of these are always mapped
  localparam int num_preg = 48;

endpackage

`default_nettype wire

// File: verilog/rob_types_pkg.sv
`default_nettype none

package rob_types_pkg;

  typedef logic [$clog2(rob_cfg_pkg::num_rob)-1:0] rob_idx_t;

  typedef logic [$clog2(rob_cfg_pkg::num_areg)-1:0] areg_t;

  typedef logic [$clog2(rob_cfg_pkg::num_preg)-1:0] preg_t;

  // one in-flight instruction
  typedef struct packed {
    logic  valid;
    logic  complete;
    logic  halt;
    areg_t dest;
    preg_t t_idx;
    // previous mapping of dest, freed at retire
    preg_t told_idx;
  } rob_entry_t;

  // committed areg to preg mapping
  typedef preg_t [rob_cfg_pkg::num_areg-1:0] arch_map_t;

endpackage

`default_nettype wire

// File: verilog/rob_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// renamed pair going from rename into the reorder buffer
interface dispatch_if;

  logic                                               fire;
  rob_types_pkg::areg_t [rob_cfg_pkg::num_super-1:0] dest;
  rob_types_pkg::preg_t [rob_cfg_pkg::num_super-1:0] t_idx;
  rob_types_pkg::preg_t [rob_cfg_pkg::num_super-1:0] told_idx;
  logic [rob_cfg_pkg::num_super-1:0]                  halt;

  modport source (output fire, dest, t_idx, told_idx, halt);
  modport sink (input fire, dest, t_idx, told_idx, halt);

endinterface

// head pair leaving the reorder buffer
interface retire_if;

  // lane 1 only ever fires together with lane 0
  logic [rob_cfg_pkg::num_super-1:0]                  retire_en;
  rob_types_pkg::areg_t [rob_cfg_pkg::num_super-1:0] dest;
  rob_types_pkg::preg_t [rob_cfg_pkg::num_super-1:0] t_idx;
  rob_types_pkg::preg_t [rob_cfg_pkg::num_super-1:0] told_idx;
  logic [rob_cfg_pkg::num_super-1:0]                  halt;

  modport source (output retire_en, dest, t_idx, told_idx, halt);
  modport sink (input retire_en, dest, t_idx, told_idx, halt);

endinterface

`default_nettype wire

// File: verilog/rename_stage.sv
`timescale 1ns/10ps
`default_nettype none

module rename_stage (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic                                               dispatch_valid,
  input  rob_types_pkg::areg_t [rob_cfg_pkg::num_super-1:0] dispatch_dest,
  input  logic [rob_cfg_pkg::num_super-1:0]                  dispatch_halt,
  input  logic                                               space_ok,
  input  logic                                               halted,
  input  logic                                               recover,
  input  rob_types_pkg::arch_map_t                           arch_map,
  input  logic [rob_cfg_pkg::num_super-1:0]                  freed_valid,
  input  rob_types_pkg::preg_t [rob_cfg_pkg::num_super-1:0] freed_idx,
  output logic                                               dispatch_ready,
  dispatch_if.source                                         disp
);

  // speculative map table
  rob_types_pkg::arch_map_t map_table;

  // one bit per physical register, set when free
  logic [rob_cfg_pkg::num_preg-1:0] free_list;
  logic [rob_cfg_pkg::num_preg-1:0] rebuilt_free;

  rob_types_pkg::preg_t [rob_cfg_pkg::num_super-1:0] alloc_idx;
  logic [rob_cfg_pkg::num_super-1:0]                  alloc_found;
  logic                                               fire;

  // two lowest free registers
  always_comb begin
    alloc_idx   = '0;
    alloc_found = '0;
    for (int p = 0; p < rob_cfg_pkg::num_preg; p++) begin
      if (free_list[p]) begin
        if (!alloc_found[0]) begin
          alloc_idx[0]   = rob_types_pkg::preg_t'(p);
          alloc_found[0] = 1'b1;
        end else if (!alloc_found[1]) begin
          alloc_idx[1]   = rob_types_pkg::preg_t'(p);
          alloc_found[1] = 1'b1;
        end
      end
    end
  end

  // free list after recovery: everything the committed map does not hold
  always_comb begin
    rebuilt_free = '1;
    for (int a = 0; a < rob_cfg_pkg::num_areg; a++) begin
      rebuilt_free[arch_map[a]] = 1'b0;
    end
  end

  // second lane found means at least two free
  assign dispatch_ready = space_ok && alloc_found[1] && !halted && !recover;
  assign fire           = dispatch_valid && dispatch_ready;

  assign disp.fire  = fire;
  assign disp.dest  = dispatch_dest;
  assign disp.halt  = dispatch_halt;
  assign disp.t_idx = alloc_idx;

  assign disp.told_idx[0] = map_table[dispatch_dest[0]];
  // same dest in both lanes, lane 1 sees lane 0's fresh register
  assign disp.told_idx[1] = (dispatch_dest[1] == dispatch_dest[0]) ? alloc_idx[0] :
                                                                     map_table[dispatch_dest[1]];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < rob_cfg_pkg::num_areg; a++) begin
        map_table[a] <= rob_types_pkg::preg_t'(a);
      end
      free_list <= {{(rob_cfg_pkg::num_preg - rob_cfg_pkg::num_areg){1'b1}},
                    {rob_cfg_pkg::num_areg{1'b0}}};
    end else if (recover) begin
      map_table <= arch_map;
      free_list <= rebuilt_free;
    end else begin
      for (int l = 0; l < rob_cfg_pkg::num_super; l++) begin
        if (freed_valid[l]) begin
          free_list[freed_idx[l]] <= 1'b1;
        end
      end
      if (fire) begin
        // lane order, so lane 1 wins on a shared dest
        for (int l = 0; l < rob_cfg_pkg::num_super; l++) begin
          free_list[alloc_idx[l]]       <= 1'b0;
          map_table[dispatch_dest[l]] <= alloc_idx[l];
        end
      end
    end
  end

  // cross-check of the priority search against a plain count
  a_alloc_two_free: assert property (@(posedge clock) disable iff (reset)
    fire |-> $countones(free_list) >= 2);

endmodule

`default_nettype wire

// File: verilog/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
  input  logic                                                  clock,
  input  logic                                                  reset,
  dispatch_if.sink                                              disp,
  input  logic [rob_cfg_pkg::num_super-1:0]                     complete_valid,
  input  rob_types_pkg::rob_idx_t [rob_cfg_pkg::num_super-1:0] complete_rob_idx,
  input  logic                                                  rollback_valid,
  input  rob_types_pkg::rob_idx_t                               rollback_rob_idx,
  input  logic                                                  halted,
  output rob_types_pkg::rob_idx_t [rob_cfg_pkg::num_super-1:0] dispatch_rob_idx,
  output logic                                                  space_ok,
  output logic                                                  recover,
  retire_if.source                                              ret
);

  typedef enum logic {
    st_normal,
    st_drain
  } drain_state_t;

  rob_types_pkg::rob_entry_t entries_q [rob_cfg_pkg::num_rob];
  rob_types_pkg::rob_entry_t entries_n [rob_cfg_pkg::num_rob];

  rob_types_pkg::rob_idx_t head_q;
  rob_types_pkg::rob_idx_t head_n;
  rob_types_pkg::rob_idx_t tail_q;
  rob_types_pkg::rob_idx_t tail_n;
  rob_types_pkg::rob_idx_t head_p1;
  rob_types_pkg::rob_idx_t tail_p1;
  // distance of the branch from head
  rob_types_pkg::rob_idx_t branch_age;

  drain_state_t state_q;
  drain_state_t state_n;

  logic                              squash;
  logic                              empty;
  logic [rob_cfg_pkg::num_super-1:0] retire_en;

  assign head_p1    = head_q + rob_types_pkg::rob_idx_t'(1);
  assign tail_p1    = tail_q + rob_types_pkg::rob_idx_t'(1);
  assign branch_age = rollback_rob_idx - head_q;

  assign dispatch_rob_idx[0] = tail_q;
  assign dispatch_rob_idx[1] = tail_p1;

  assign squash   = rollback_valid && entries_q[rollback_rob_idx].valid;
  assign empty    = (head_q == tail_q) && !entries_q[head_q].valid;
  assign recover  = (state_q == st_drain) && empty;
  assign space_ok = (state_q == st_normal) && !entries_q[tail_q].valid &&
                    !entries_q[tail_p1].valid;

  assign retire_en[0] = entries_q[head_q].valid && entries_q[head_q].complete &&
                        !rollback_valid && !halted;
  assign retire_en[1] = retire_en[0] && entries_q[head_p1].valid &&
                        entries_q[head_p1].complete;

  // head pair offered to retire
  always_comb begin
    ret.retire_en = retire_en;
    for (int l = 0; l < rob_cfg_pkg::num_super; l++) begin
      ret.dest[l]     = entries_q[head_q + rob_types_pkg::rob_idx_t'(l)].dest;
      ret.t_idx[l]    = entries_q[head_q + rob_types_pkg::rob_idx_t'(l)].t_idx;
      ret.told_idx[l] = entries_q[head_q + rob_types_pkg::rob_idx_t'(l)].told_idx;
      ret.halt[l]     = entries_q[head_q + rob_types_pkg::rob_idx_t'(l)].halt;
    end
  end

  always_comb begin
    entries_n = entries_q;
    head_n    = head_q;
    tail_n    = tail_q;
    state_n   = state_q;

    // completions to squashed or empty slots are dropped
    for (int l = 0; l < rob_cfg_pkg::num_super; l++) begin
      if (complete_valid[l] && entries_q[complete_rob_idx[l]].valid) begin
        entries_n[complete_rob_idx[l]].complete = 1'b1;
      end
    end

    if (retire_en[0]) begin
      entries_n[head_q].valid = 1'b0;
      head_n                  = head_p1;
    end
    if (retire_en[1]) begin
      entries_n[head_p1].valid = 1'b0;
      head_n                   = head_q + rob_types_pkg::rob_idx_t'(2);
    end

    if (disp.fire) begin
      for (int l = 0; l < rob_cfg_pkg::num_super; l++) begin
        entries_n[tail_q + rob_types_pkg::rob_idx_t'(l)] = '{
          valid:    1'b1,
          complete: 1'b0,
          halt:     disp.halt[l],
          dest:     disp.dest[l],
          t_idx:    disp.t_idx[l],
          told_idx: disp.told_idx[l]
        };
      end
      tail_n = tail_q + rob_types_pkg::rob_idx_t'(2);
    end

    // age taken from head so the squash works across the wrap
    if (squash) begin
      for (int i = 0; i < rob_cfg_pkg::num_rob; i++) begin
        if (rob_types_pkg::rob_idx_t'(rob_types_pkg::rob_idx_t'(i) - head_q) > branch_age) begin
          entries_n[i].valid = 1'b0;
        end
      end
      tail_n  = rollback_rob_idx + rob_types_pkg::rob_idx_t'(1);
      state_n = st_drain;
    end else if (recover) begin
      state_n = st_normal;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      state_q <= st_normal;
      for (int i = 0; i < rob_cfg_pkg::num_rob; i++) begin
        entries_q[i].valid    <= 1'b0;
        entries_q[i].complete <= 1'b0;
      end
    end else begin
      head_q    <= head_n;
      tail_q    <= tail_n;
      state_q   <= state_n;
      entries_q <= entries_n;
    end
  end

  // rename must hold back while the buffer is full or draining
  a_fire_space: assert property (@(posedge clock) disable iff (reset)
    disp.fire |-> space_ok);

endmodule

`default_nettype wire

// File: verilog/retire_stage.sv
`timescale 1ns/10ps
`default_nettype none

module retire_stage (
  input  logic                                               clock,
  input  logic                                               reset,
  retire_if.sink                                             ret,
  output logic [rob_cfg_pkg::num_super-1:0]                  retire_valid,
  output rob_types_pkg::areg_t [rob_cfg_pkg::num_super-1:0] retire_dest,
  output rob_types_pkg::preg_t [rob_cfg_pkg::num_super-1:0] retire_t_idx,
  output rob_types_pkg::arch_map_t                           arch_map,
  output logic [rob_cfg_pkg::num_super-1:0]                  freed_valid,
  output rob_types_pkg::preg_t [rob_cfg_pkg::num_super-1:0] freed_idx,
  output logic                                               halted
);

  assign retire_valid = ret.retire_en;
  assign retire_dest  = ret.dest;
  assign retire_t_idx = ret.t_idx;

  // old mapping goes back to the free list at the retire edge
  assign freed_valid = ret.retire_en;
  assign freed_idx   = ret.told_idx;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < rob_cfg_pkg::num_areg; a++) begin
        arch_map[a] <= rob_types_pkg::preg_t'(a);
      end
      halted <= 1'b0;
    end else begin
      // lane order, lane 1 wins on the same dest
      for (int l = 0; l < rob_cfg_pkg::num_super; l++) begin
        if (ret.retire_en[l]) begin
          arch_map[ret.dest[l]] <= ret.t_idx[l];
        end
      end
      // sticky until reset
      if (|(ret.retire_en & ret.halt)) begin
        halted <= 1'b1;
      end
    end
  end

  a_lane_order: assert property (@(posedge clock) disable iff (reset)
    ret.retire_en[1] |-> ret.retire_en[0]);

endmodule

`default_nettype wire

// File: verilog/rename_rob_top.sv
`timescale 1ns/10ps
`default_nettype none

module rename_rob_top (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic                                                  dispatch_valid,
  input  rob_types_pkg::areg_t [rob_cfg_pkg::num_super-1:0]    dispatch_dest,
  input  logic [rob_cfg_pkg::num_super-1:0]                     dispatch_halt,
  input  logic [rob_cfg_pkg::num_super-1:0]                     complete_valid,
  input  rob_types_pkg::rob_idx_t [rob_cfg_pkg::num_super-1:0] complete_rob_idx,
  input  logic                                                  rollback_valid,
  input  rob_types_pkg::rob_idx_t                               rollback_rob_idx,
  output logic                                                  dispatch_ready,
  output rob_types_pkg::rob_idx_t [rob_cfg_pkg::num_super-1:0] dispatch_rob_idx,
  output logic [rob_cfg_pkg::num_super-1:0]                     retire_valid,
  output rob_types_pkg::areg_t [rob_cfg_pkg::num_super-1:0]    retire_dest,
  output rob_types_pkg::preg_t [rob_cfg_pkg::num_super-1:0]    retire_t_idx,
  output logic                                                  halted
);

  logic                                               space_ok;
  logic                                               recover;
  rob_types_pkg::arch_map_t                           arch_map;
  logic [rob_cfg_pkg::num_super-1:0]                  freed_valid;
  rob_types_pkg::preg_t [rob_cfg_pkg::num_super-1:0] freed_idx;

  dispatch_if disp_bus ();
  retire_if   ret_bus ();

  rename_stage i_rename_stage (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_dest  (dispatch_dest),
    .dispatch_halt  (dispatch_halt),
    .space_ok       (space_ok),
    .halted         (halted),
    .recover        (recover),
    .arch_map       (arch_map),
    .freed_valid    (freed_valid),
    .freed_idx      (freed_idx),
    .dispatch_ready (dispatch_ready),
    .disp           (disp_bus.source)
  );

  reorder_buffer i_reorder_buffer (
    .clock            (clock),
    .reset            (reset),
    .disp             (disp_bus.sink),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .rollback_valid   (rollback_valid),
    .rollback_rob_idx (rollback_rob_idx),
    .halted           (halted),
    .dispatch_rob_idx (dispatch_rob_idx),
    .space_ok         (space_ok),
    .recover          (recover),
    .ret              (ret_bus.source)
  );

  retire_stage i_retire_stage (
    .clock        (clock),
    .reset        (reset),
    .ret          (ret_bus.sink),
    .retire_valid (retire_valid),
    .retire_dest  (retire_dest),
    .retire_t_idx (retire_t_idx),
    .arch_map     (arch_map),
    .freed_valid  (freed_valid),
    .freed_idx    (freed_idx),
    .halted       (halted)
  );

endmodule

`default_nettype wire

// File: dv/rob_ref_model.svh
// model of map table, free list, buffer and committed state, stepped at each rising edge
rob_types_pkg::preg_t      m_map [rob_cfg_pkg::num_areg];
rob_types_pkg::preg_t      m_arch [rob_cfg_pkg::num_areg];
bit                        m_free [rob_cfg_pkg::num_preg];
rob_types_pkg::rob_entry_t m_rob [rob_cfg_pkg::num_rob];
int                        m_head;
int                        m_tail;
int                        m_count;
bit                        m_drain;
bit                        m_halted;

function automatic void model_reset();
  for (int a = 0; a < rob_cfg_pkg::num_areg; a++) begin
    m_map[a]  = rob_types_pkg::preg_t'(a);
    m_arch[a] = rob_types_pkg::preg_t'(a);
  end
  for (int p = 0; p < rob_cfg_pkg::num_preg; p++) begin
    m_free[p] = (p >= rob_cfg_pkg::num_areg);
  end
  m_rob    = '{default: '0};
  m_head   = 0;
  m_tail   = 0;
  m_count  = 0;
  m_drain  = 1'b0;
  m_halted = 1'b0;
endfunction

// lowest free register above the given one
function automatic int lowest_free(input int above);
  for (int p = above + 1; p < rob_cfg_pkg::num_preg; p++) begin
    if (m_free[p]) begin
      return p;
    end
  end
  return rob_cfg_pkg::num_preg;
endfunction

function automatic bit model_recover();
  return m_drain && (m_count == 0);
endfunction

function automatic bit model_ready();
  return !m_drain && (m_count <= rob_cfg_pkg::num_rob - 2) && !m_halted &&
         (lowest_free(lowest_free(-1)) < rob_cfg_pkg::num_preg) && !model_recover();
endfunction

function automatic bit model_retire(input int lane);
  rob_types_pkg::rob_entry_t e0;
  rob_types_pkg::rob_entry_t e1;
  e0 = m_rob[m_head];
  e1 = m_rob[(m_head + 1) % rob_cfg_pkg::num_rob];
  if (rollback_valid || m_halted || !(e0.valid && e0.complete)) begin
    return 1'b0;
  end
  return (lane == 0) || (e1.valid && e1.complete);
endfunction

function automatic void model_step();
  rob_types_pkg::rob_entry_t pair [2];
  bit [1:0] ret;
  bit       fire;
  bit       rec;
  bit       squash;
  int       idx;
  int       age;
  fire    = dispatch_valid && model_ready();
  rec     = model_recover();
  ret     = {model_retire(1), model_retire(0)};
  squash  = rollback_valid && m_rob[rollback_rob_idx].valid;
  pair[0] = '{1'b1, 1'b0, dispatch_halt[0], dispatch_dest[0],
              rob_types_pkg::preg_t'(lowest_free(-1)), m_map[dispatch_dest[0]]};
  pair[1] = '{1'b1, 1'b0, dispatch_halt[1], dispatch_dest[1],
              rob_types_pkg::preg_t'(lowest_free(lowest_free(-1))), m_map[dispatch_dest[1]]};
  // lane 1 replaces lane 0's fresh mapping on a shared dest
  if (dispatch_dest[1] == dispatch_dest[0]) begin
    pair[1].told_idx = pair[0].t_idx;
  end
  if (rec) begin
    for (int p = 0; p < rob_cfg_pkg::num_preg; p++) begin
      m_free[p] = 1'b1;
    end
    for (int a = 0; a < rob_cfg_pkg::num_areg; a++) begin
      m_map[a]         = m_arch[a];
      m_free[m_arch[a]] = 1'b0;
    end
  end
  for (int l = 0; l < 2; l++) begin
    idx = (m_head + l) % rob_cfg_pkg::num_rob;
    if (ret[l]) begin
      m_free[m_rob[idx].told_idx] = 1'b1;
      m_arch[m_rob[idx].dest]     = m_rob[idx].t_idx;
      m_halted                    = m_halted | m_rob[idx].halt;
      m_rob[idx].valid            = 1'b0;
    end
    if (complete_valid[l] && m_rob[complete_rob_idx[l]].valid) begin
      m_rob[complete_rob_idx[l]].complete = 1'b1;
    end
  end
  if (fire) begin
    for (int l = 0; l < 2; l++) begin
      m_free[pair[l].t_idx] = 1'b0;
      m_map[pair[l].dest]   = pair[l].t_idx;
      m_rob[(m_tail + l) % rob_cfg_pkg::num_rob] = pair[l];
    end
    m_tail  = (m_tail + 2) % rob_cfg_pkg::num_rob;
    m_count = m_count + 2;
  end
  m_head  = (m_head + int'(ret[0]) + int'(ret[1])) % rob_cfg_pkg::num_rob;
  m_count = m_count - int'(ret[0]) - int'(ret[1]);
  // everything younger than the branch goes
  if (squash) begin
    age = (int'(rollback_rob_idx) - m_head + rob_cfg_pkg::num_rob) % rob_cfg_pkg::num_rob;
    for (int i = 0; i < rob_cfg_pkg::num_rob; i++) begin
      if ((i - m_head + rob_cfg_pkg::num_rob) % rob_cfg_pkg::num_rob > age) begin
        m_rob[i].valid = 1'b0;
      end
    end
    m_tail  = (int'(rollback_rob_idx) + 1) % rob_cfg_pkg::num_rob;
    m_count = age + 1;
    m_drain = 1'b1;
  end else if (rec) begin
    m_drain = 1'b0;
  end
endfunction

// File: dv/tb_rename_rob.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rename_rob;

  // cycles per test, the run limit is twice their sum
  localparam int len_reset    = 10;
  localparam int len_retire   = 500;
  localparam int len_rename   = 400;
  localparam int len_pressure = 300;
  localparam int len_rollback = 600;
  localparam int len_halt     = 190;
  localparam int cycle_limit  = 2 * (len_reset + len_retire + len_rename + len_pressure +
                                     len_rollback + len_halt);

  logic                          clock;
  logic                          reset;
  logic                          dispatch_valid;
  rob_types_pkg::areg_t [1:0]    dispatch_dest;
  logic [1:0]                    dispatch_halt;
  logic [1:0]                    complete_valid;
  rob_types_pkg::rob_idx_t [1:0] complete_rob_idx;
  logic                          rollback_valid;
  rob_types_pkg::rob_idx_t       rollback_rob_idx;
  logic                          dispatch_ready;
  rob_types_pkg::rob_idx_t [1:0] dispatch_rob_idx;
  logic [1:0]                    retire_valid;
  rob_types_pkg::areg_t [1:0]    retire_dest;
  rob_types_pkg::preg_t [1:0]    retire_t_idx;
  logic                          halted;

  integer seed = 32'hd54c_bc67;
  int     cycle_count = 0;
  int     test_errors = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;

  `include "rob_ref_model.svh"

  rename_rob_top i_rename_rob_top (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      test_errors++;
    end
  endtask

  function automatic bit chance(input int percent);
    return ($unsigned($random(seed)) % 100) < percent;
  endfunction

  // random in-flight slot, anywhere when the buffer is empty
  function automatic rob_types_pkg::rob_idx_t in_flight_idx();
    if (m_count == 0) begin
      return rob_types_pkg::rob_idx_t'($random(seed));
    end
    return rob_types_pkg::rob_idx_t'(m_head + $unsigned($random(seed)) % m_count);
  endfunction

  task automatic drive_random(input int disp_pct, input int comp_pct, input int rb_pct,
                              input int halt_pct);
    dispatch_valid = chance(disp_pct);
    for (int l = 0; l < 2; l++) begin
      dispatch_dest[l]    = rob_types_pkg::areg_t'($random(seed));
      dispatch_halt[l]    = chance(halt_pct);
      complete_valid[l]   = chance(comp_pct);
      complete_rob_idx[l] = in_flight_idx();
    end
    rollback_valid   = chance(rb_pct);
    rollback_rob_idx = in_flight_idx();
  endtask

  task automatic compare_outputs();
    int idx;
    check_value("dispatch_ready", dispatch_ready, model_ready());
    check_value("halted", halted, m_halted);
    for (int l = 0; l < 2; l++) begin
      idx = (m_head + l) % rob_cfg_pkg::num_rob;
      check_value($sformatf("dispatch_rob_idx[%0d]", l), dispatch_rob_idx[l],
                  (m_tail + l) % rob_cfg_pkg::num_rob);
      check_value($sformatf("retire_valid[%0d]", l), retire_valid[l], model_retire(l));
      if (model_retire(l)) begin
        check_value($sformatf("retire_dest[%0d]", l), retire_dest[l], m_rob[idx].dest);
        check_value($sformatf("retire_t_idx[%0d]", l), retire_t_idx[l], m_rob[idx].t_idx);
      end
    end
  endtask

  // check mid-cycle, then advance the model with the edge
  task automatic step();
    #1;
    compare_outputs();
    @(posedge clock);
    model_step();
    #1;
  endtask

  task automatic apply_reset();
    reset            = 1'b1;
    dispatch_valid   = 1'b0;
    dispatch_dest    = '0;
    dispatch_halt    = '0;
    complete_valid   = '0;
    complete_rob_idx = '0;
    rollback_valid   = 1'b0;
    rollback_rob_idx = '0;
    model_reset();
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic run_random(input string name, input int cycles, input int disp_pct,
                            input int comp_pct, input int rb_pct);
    apply_reset();
    repeat (cycles) begin
      drive_random(disp_pct, comp_pct, rb_pct, 0);
      step();
    end
    finish_test(name);
  endtask

  initial begin
    apply_reset();
    #1;
    check_value("dispatch_ready", dispatch_ready, 1);
    check_value("retire_valid", retire_valid, 0);
    check_value("halted", halted, 0);
    finish_test("reset state");

    run_random("in-order retire", len_retire, 60, 40, 0);
    run_random("renaming and freeing", len_rename, 90, 70, 0);

    // no completions until buffer and free list both run dry
    apply_reset();
    repeat (len_pressure / 3) begin
      drive_random(100, 0, 0, 0);
      step();
    end
    repeat (len_pressure - len_pressure / 3) begin
      drive_random(100, 80, 0, 0);
      step();
    end
    finish_test("back-pressure");

    run_random("rollback and recovery", len_rollback, 70, 50, 4);

    // once a halt retires nothing else may
    apply_reset();
    while (!halted) begin
      drive_random(70, 60, 0, 10);
      step();
    end
    repeat (50) begin
      drive_random(70, 60, 0, 0);
      step();
      check_value("retire_valid", retire_valid, 0);
    end
    apply_reset();
    #1;
    check_value("halted", halted, 0);
    finish_test("halt");

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+dv
verilog/rob_cfg_pkg.sv
verilog/rob_types_pkg.sv
verilog/rob_ifs.sv
verilog/rename_stage.sv
verilog/reorder_buffer.sv
verilog/retire_stage.sv
verilog/rename_rob_top.sv
dv/tb_rename_rob.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rename and commit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_rename_rob --Mdir obj_dir -o sim_rename_rob > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_rename_rob > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  echo "FAIL, see sim.log"
  exit 1
fi
echo "PASS"
exit 0
